//--- include/minrv_config.svh
// core-wide constants for the minrv RV32I core
// include wherever a width or a reset value is needed
`ifndef MINRV_CONFIG_SVH
`define MINRV_CONFIG_SVH

// data and address width
`define MINRV_XLEN 32

// architectural registers
`define MINRV_REGS 32

// first fetch address after reset
`define MINRV_RESET_PC 32'h0001_0000

// x2 after reset
`define MINRV_STACK_ADDR 32'h0001_0000

`endif

//--- hdl/rv_isa_pkg.sv
// RV32I instruction encodings and the decoded control word
// shared by the decoder, the execute unit and the core top
`default_nettype none

`include "minrv_config.svh"

package rv_isa_pkg;

	// major opcodes handled by the core, anything else is illegal
	typedef enum logic [6:0] {
		opc_lui    = 7'b0110111,
		opc_auipc  = 7'b0010111,
		opc_jal    = 7'b1101111,
		opc_jalr   = 7'b1100111,
		opc_branch = 7'b1100011,
		opc_load   = 7'b0000011,
		opc_store  = 7'b0100011,
		opc_op_imm = 7'b0010011,
		opc_op     = 7'b0110011
	} opcode_e;

	typedef enum logic [3:0] {
		alu_add  = 4'd0, // also load/store address and jalr target
		alu_sub  = 4'd1,
		alu_sll  = 4'd2,
		alu_slt  = 4'd3,
		alu_sltu = 4'd4,
		alu_xor  = 4'd5,
		alu_srl  = 4'd6,
		alu_sra  = 4'd7,
		alu_or   = 4'd8,
		alu_and  = 4'd9
	} alu_op_e;

	// rd source
	typedef enum logic [1:0] {
		wb_alu   = 2'd0,
		wb_load  = 2'd1,
		wb_link  = 2'd2, // pc + 4
		wb_upper = 2'd3  // pc + upper immediate
	} wb_sel_e;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcode_e    opcode;
	} insn_fields_t;

	typedef struct packed {
		logic                   uses_rs1;
		logic                   uses_rs2;
		logic                   writes_rd;
		alu_op_e                alu_op;
		logic                   imm_b;     // operand b is the immediate
		logic                   is_load;
		logic                   is_store;
		logic                   is_branch;
		logic                   is_jal;
		logic                   is_jalr;
		wb_sel_e                wb_sel;
		logic [2:0]             funct3;    // branch condition or access size
		logic [`MINRV_XLEN-1:0] imm;       // already sign extended
	} decode_t;

endpackage

`default_nettype wire

//--- hdl/core_bus_pkg.sv
// data bus request and register write types
// travel between the execute unit, the register file and the core top
`default_nettype none

`include "minrv_config.svh"

package core_bus_pkg;

	typedef logic [$clog2(`MINRV_REGS)-1:0] reg_addr_t;

	// one data access, strobes and mask use the low lanes
	typedef struct packed {
		logic                   valid;
		logic [`MINRV_XLEN-1:0] addr;
		logic [`MINRV_XLEN-1:0] wdata;
		logic [3:0]             wstrb;
		logic [3:0]             rmask;
	} mem_req_t;

	typedef struct packed {
		logic                   en;
		reg_addr_t              addr;
		logic [`MINRV_XLEN-1:0] data;
	} rf_write_t;

endpackage

`default_nettype wire

//--- hdl/insn_decoder.sv
// RV32I decoder, purely combinational
// splits the fetched word into control flags, immediate and register indices
// and flags every encoding the core does not implement
`timescale 1ns/1ns
`default_nettype none

module insn_decoder (
	input  rv_isa_pkg::insn_fields_t insn,
	output rv_isa_pkg::decode_t      dec,
	output core_bus_pkg::reg_addr_t  rs1_addr,
	output core_bus_pkg::reg_addr_t  rs2_addr,
	output logic                     illegal
);
	import rv_isa_pkg::*;

	logic [31:0] w;
	logic [31:0] i_imm;
	logic [31:0] s_imm;
	logic [31:0] b_imm;
	logic [31:0] j_imm;
	logic [31:0] u_imm;

	assign w     = insn;
	assign i_imm = {{20{w[31]}}, w[31:20]};
	assign s_imm = {{20{w[31]}}, w[31:25], w[11:7]};
	assign b_imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
	assign j_imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
	assign u_imm = {w[31:12], 12'b0};

	always_comb begin
		dec = '0;
		dec.funct3 = insn.funct3;
		illegal = 1'b1;
		case (insn.opcode)
			opc_lui: begin
				illegal = 1'b0;
				dec.writes_rd = 1'b1;
				dec.imm_b = 1'b1; // x0 + imm through the alu
				dec.imm = u_imm;
			end
			opc_auipc: begin
				illegal = 1'b0;
				dec.writes_rd = 1'b1;
				dec.wb_sel = wb_upper;
				dec.imm = u_imm;
			end
			opc_jal: begin
				illegal = 1'b0;
				dec.writes_rd = 1'b1;
				dec.is_jal = 1'b1;
				dec.wb_sel = wb_link;
				dec.imm = j_imm;
			end
			opc_jalr: begin
				illegal = (insn.funct3 != 3'b000);
				dec.uses_rs1 = 1'b1;
				dec.writes_rd = 1'b1;
				dec.imm_b = 1'b1;
				dec.is_jalr = 1'b1;
				dec.wb_sel = wb_link;
				dec.imm = i_imm;
			end
			opc_branch: begin
				illegal = (insn.funct3 == 3'b010) || (insn.funct3 == 3'b011);
				dec.uses_rs1 = 1'b1;
				dec.uses_rs2 = 1'b1;
				dec.is_branch = 1'b1;
				dec.imm = b_imm;
			end
			opc_load: begin
				// lb lh lw lbu lhu
				illegal = (insn.funct3 == 3'b011) || (insn.funct3[2:1] == 2'b11);
				dec.uses_rs1 = 1'b1;
				dec.writes_rd = 1'b1;
				dec.imm_b = 1'b1;
				dec.is_load = 1'b1;
				dec.wb_sel = wb_load;
				dec.imm = i_imm;
			end
			opc_store: begin
				illegal = (insn.funct3[2] || insn.funct3[1:0] == 2'b11);
				dec.uses_rs1 = 1'b1;
				dec.uses_rs2 = 1'b1;
				dec.imm_b = 1'b1;
				dec.is_store = 1'b1;
				dec.imm = s_imm;
			end
			opc_op_imm, opc_op: begin
				dec.uses_rs1 = 1'b1;
				dec.uses_rs2 = (insn.opcode == opc_op);
				dec.writes_rd = 1'b1;
				dec.imm_b = (insn.opcode == opc_op_imm);
				dec.imm = i_imm;
				case (insn.funct3)
					3'b000: begin
						if (dec.imm_b || insn.funct7 == 7'b0000000) begin
							illegal = 1'b0;
						end else if (insn.funct7 == 7'b0100000) begin
							illegal = 1'b0;
							dec.alu_op = alu_sub;
						end
					end
					3'b001: begin
						illegal = (insn.funct7 != 7'b0000000); // also slli shamt[5]
						dec.alu_op = alu_sll;
					end
					3'b101: begin
						illegal = (insn.funct7 != 7'b0000000) && (insn.funct7 != 7'b0100000);
						dec.alu_op = insn.funct7[5] ? alu_sra : alu_srl;
					end
					default: begin
						illegal = !dec.imm_b && (insn.funct7 != 7'b0000000);
						case (insn.funct3)
							3'b010:  dec.alu_op = alu_slt;
							3'b011:  dec.alu_op = alu_sltu;
							3'b100:  dec.alu_op = alu_xor;
							3'b110:  dec.alu_op = alu_or;
							default: dec.alu_op = alu_and;
						endcase
					end
				endcase
			end
			default: illegal = 1'b1; // includes system/csr
		endcase
		if (illegal) begin
			dec = '0; // no side effects from a bad word
		end
	end

	// unused ports read x0
	assign rs1_addr = dec.uses_rs1 ? insn.rs1 : '0;
	assign rs2_addr = dec.uses_rs2 ? insn.rs2 : '0;

endmodule

`default_nettype wire

//--- hdl/exec_unit.sv
// execute datapath of the single-cycle core, purely combinational
// alu, branch compare, next pc, load extension and store strobes
// loads and stores use the low byte lanes of the data bus
`timescale 1ns/1ns
`default_nettype none

`include "minrv_config.svh"

module exec_unit (
	input  logic [`MINRV_XLEN-1:0]  pc,
	input  rv_isa_pkg::decode_t     dec,
	input  logic [`MINRV_XLEN-1:0]  rs1_data,
	input  logic [`MINRV_XLEN-1:0]  rs2_data,
	input  core_bus_pkg::reg_addr_t rd_addr,
	input  logic [`MINRV_XLEN-1:0]  mem_rdata,
	output core_bus_pkg::mem_req_t  mem_req,
	output core_bus_pkg::rf_write_t rd_wr,
	output logic [`MINRV_XLEN-1:0]  next_pc,
	output logic                    misaligned
);
	import rv_isa_pkg::*;

	logic [`MINRV_XLEN-1:0] op_b;
	logic [4:0]             shamt;
	logic [`MINRV_XLEN-1:0] alu_out;
	logic                   lt_s;
	logic                   lt_u;
	logic                   take_branch;
	logic [`MINRV_XLEN-1:0] pc_plus4;
	logic [`MINRV_XLEN-1:0] pc_rel;
	logic [3:0]             size_mask;
	logic [`MINRV_XLEN-1:0] load_data;

	assign op_b  = dec.imm_b ? dec.imm : rs2_data;
	assign shamt = op_b[4:0];
	assign lt_s  = $signed(rs1_data) < $signed(op_b); // shared by slt and branches
	assign lt_u  = rs1_data < op_b;

	always_comb begin
		case (dec.alu_op)
			alu_sub:  alu_out = rs1_data - op_b;
			alu_sll:  alu_out = rs1_data << shamt;
			alu_slt:  alu_out = {31'b0, lt_s};
			alu_sltu: alu_out = {31'b0, lt_u};
			alu_xor:  alu_out = rs1_data ^ op_b;
			alu_srl:  alu_out = rs1_data >> shamt;
			alu_sra:  alu_out = $signed(rs1_data) >>> shamt;
			alu_or:   alu_out = rs1_data | op_b;
			alu_and:  alu_out = rs1_data & op_b;
			default:  alu_out = rs1_data + op_b;
		endcase
	end

	always_comb begin
		case (dec.funct3)
			3'b000:  take_branch = (rs1_data == op_b);
			3'b001:  take_branch = (rs1_data != op_b);
			3'b100:  take_branch = lt_s;
			3'b101:  take_branch = !lt_s;
			3'b110:  take_branch = lt_u;
			3'b111:  take_branch = !lt_u;
			default: take_branch = 1'b0;
		endcase
	end

	assign pc_plus4 = pc + 32'd4;
	assign pc_rel   = pc + dec.imm; // branch, jal and auipc

	always_comb begin
		if (dec.is_jalr) begin
			next_pc = {alu_out[31:1], 1'b0};
		end else if (dec.is_jal || (dec.is_branch && take_branch)) begin
			next_pc = pc_rel;
		end else begin
			next_pc = pc_plus4;
		end
	end

	// pc is always aligned, so only a taken target can trip this
	assign misaligned = |next_pc[1:0];

	always_comb begin
		case (dec.funct3[1:0])
			2'b00:   size_mask = 4'b0001;
			2'b01:   size_mask = 4'b0011;
			default: size_mask = 4'b1111;
		endcase
	end

	always_comb begin
		case (dec.funct3)
			3'b000:  load_data = {{24{mem_rdata[7]}}, mem_rdata[7:0]};
			3'b001:  load_data = {{16{mem_rdata[15]}}, mem_rdata[15:0]};
			3'b100:  load_data = {24'b0, mem_rdata[7:0]};
			3'b101:  load_data = {16'b0, mem_rdata[15:0]};
			default: load_data = mem_rdata;
		endcase
	end

	always_comb begin
		mem_req.valid = dec.is_load || dec.is_store;
		mem_req.addr  = alu_out;
		mem_req.wdata = dec.is_store ? rs2_data : '0;
		mem_req.wstrb = dec.is_store ? size_mask : 4'b0000;
		mem_req.rmask = dec.is_load ? size_mask : 4'b0000;
	end

	always_comb begin
		rd_wr.en   = dec.writes_rd;
		rd_wr.addr = rd_addr;
		case (dec.wb_sel)
			wb_load:  rd_wr.data = load_data;
			wb_link:  rd_wr.data = pc_plus4;
			wb_upper: rd_wr.data = pc_rel;
			default:  rd_wr.data = alu_out;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/reg_file.sv
// architectural register file, two combinational reads and one write
// x0 reads as zero, x2 comes out of reset holding the stack address
`timescale 1ns/1ns
`default_nettype none

`include "minrv_config.svh"

module reg_file (
	input  logic                    clk,
	input  logic                    resetn,
	input  core_bus_pkg::reg_addr_t rs1_addr,
	input  core_bus_pkg::reg_addr_t rs2_addr,
	output logic [`MINRV_XLEN-1:0]  rs1_data,
	output logic [`MINRV_XLEN-1:0]  rs2_data,
	input  core_bus_pkg::rf_write_t wr
);
	logic [`MINRV_XLEN-1:0] regs [`MINRV_REGS];

	always_ff @(posedge clk) begin
		if (!resetn) begin
			regs[2] <= `MINRV_STACK_ADDR; // sp
		end else if (wr.en && wr.addr != '0) begin
			regs[wr.addr] <= wr.data;
		end
	end

	// x0 never written, masked on read
	assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

//--- hdl/minrv_core.sv
// top of the minrv RV32I core, one instruction at a time with no pipeline
// fetch answers in the same cycle, data accesses stall until mem_ready
// a trapping instruction writes nothing and the core halts there until reset
`timescale 1ns/1ns
`default_nettype none

`include "minrv_config.svh"

module minrv_core (
	input  logic                   clk,
	input  logic                   resetn,
	output logic [`MINRV_XLEN-1:0] insn_addr,
	input  logic [`MINRV_XLEN-1:0] insn,
	output logic                   mem_valid,
	output logic                   mem_instr,
	input  logic                   mem_ready,
	output logic [`MINRV_XLEN-1:0] mem_addr,
	output logic [`MINRV_XLEN-1:0] mem_wdata,
	output logic [3:0]             mem_wstrb,
	output logic [3:0]             mem_rmask,
	input  logic [`MINRV_XLEN-1:0] mem_rdata,
	output logic                   trap
);
	import rv_isa_pkg::*;
	import core_bus_pkg::*;

	logic [`MINRV_XLEN-1:0] pc;
	logic [`MINRV_XLEN-1:0] next_pc;
	logic                   halted;
	logic                   illegal;
	logic                   misaligned;
	logic                   complete;
	logic                   commit;
	insn_fields_t           insn_f;
	decode_t                dec;
	reg_addr_t              rs1_addr;
	reg_addr_t              rs2_addr;
	logic [`MINRV_XLEN-1:0] rs1_data;
	logic [`MINRV_XLEN-1:0] rs2_data;
	mem_req_t               mem_req;
	rf_write_t              rd_prop;
	rf_write_t              rd_wr;

	assign insn_f    = insn;
	assign insn_addr = pc;

	assign complete = !mem_req.valid || mem_ready; // no access, or access acked
	assign trap     = halted || illegal || misaligned;
	assign commit   = complete && !trap;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			pc     <= `MINRV_RESET_PC;
			halted <= 1'b0;
		end else begin
			if (trap) begin
				halted <= 1'b1; // sticky until reset
			end
			if (commit) begin
				pc <= next_pc;
			end
		end
	end

	insn_decoder u_decoder (
		.insn     (insn_f),
		.dec      (dec),
		.rs1_addr (rs1_addr),
		.rs2_addr (rs2_addr),
		.illegal  (illegal)
	);

	reg_file u_regs (
		.clk      (clk),
		.resetn   (resetn),
		.rs1_addr (rs1_addr),
		.rs2_addr (rs2_addr),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.wr       (rd_wr)
	);

	exec_unit u_exec (
		.pc         (pc),
		.dec        (dec),
		.rs1_data   (rs1_data),
		.rs2_data   (rs2_data),
		.rd_addr    (insn_f.rd),
		.mem_rdata  (mem_rdata),
		.mem_req    (mem_req),
		.rd_wr      (rd_prop),
		.next_pc    (next_pc),
		.misaligned (misaligned)
	);

	// rd only lands in the completing cycle
	always_comb begin
		rd_wr    = rd_prop;
		rd_wr.en = rd_prop.en && commit;
	end

	assign mem_valid = mem_req.valid;
	assign mem_instr = 1'b0; // fetch has its own port
	assign mem_addr  = mem_req.addr;
	assign mem_wdata = mem_req.wdata;
	assign mem_wstrb = commit ? mem_req.wstrb : 4'b0000; // store commits once
	assign mem_rmask = mem_req.rmask;

endmodule

`default_nettype wire

//--- testbench/tb_minrv_core.sv
// testbench for the minrv core
// runs two random RV32I programs against a reference instruction model
// while mem_ready drops on random cycles
// the first program ends on a CSR word and the second on a misaligned JALR
`timescale 1ns/1ns
`default_nettype none

`include "minrv_config.svh"

module tb_minrv_core;

	localparam int          PROG_LEN        = 160;
	localparam int          WIN_WORDS       = 16;
	localparam logic [31:0] DATA_BASE       = 32'h0002_0000;
	localparam int          WATCHDOG_CYCLES = 2 * (PROG_LEN * 8 + 100); // two programs

	localparam logic [31:0] OPC_LUI    = 32'h37;
	localparam logic [31:0] OPC_AUIPC  = 32'h17;
	localparam logic [31:0] OPC_JAL    = 32'h6f;
	localparam logic [31:0] OPC_JALR   = 32'h67;
	localparam logic [31:0] OPC_BRANCH = 32'h63;
	localparam logic [31:0] OPC_LOAD   = 32'h03;
	localparam logic [31:0] OPC_STORE  = 32'h23;
	localparam logic [31:0] OPC_IMM    = 32'h13;
	localparam logic [31:0] OPC_OP     = 32'h33;

	logic        clk;
	logic        resetn;
	logic [31:0] insn_addr;
	logic [31:0] insn;
	logic        mem_valid;
	logic        mem_instr;
	logic        mem_ready;
	logic [31:0] mem_addr;
	logic [31:0] mem_wdata;
	logic [3:0]  mem_wstrb;
	logic [3:0]  mem_rmask;
	logic [31:0] mem_rdata;
	logic        trap;

	integer      seed = 32'h41b8_f9d6;
	int          errors;
	logic [31:0] imem [256];
	logic [31:0] dmem [WIN_WORDS];

	// reference model state
	logic [31:0] m_regs [32];
	logic [31:0] m_mem [WIN_WORDS];
	logic [31:0] m_pc;
	logic        m_halted;

	// prediction for the instruction at m_pc
	logic        p_bad;
	logic        p_load;
	logic        p_store;
	logic        p_wr;
	logic [4:0]  p_rd;
	logic [31:0] p_res;
	logic [31:0] p_npc;
	logic [31:0] p_addr;
	logic [31:0] p_wdata;
	logic [3:0]  p_wstrb;
	logic [3:0]  p_rmask;

	minrv_core i_dut (
		.clk       (clk),
		.resetn    (resetn),
		.insn_addr (insn_addr),
		.insn      (insn),
		.mem_valid (mem_valid),
		.mem_instr (mem_instr),
		.mem_ready (mem_ready),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_wstrb (mem_wstrb),
		.mem_rmask (mem_rmask),
		.mem_rdata (mem_rdata),
		.trap      (trap)
	);

	always #5 clk = ~clk;

	// same-cycle memories, word indexed
	assign insn      = imem[insn_addr[9:2]];
	assign mem_rdata = dmem[mem_addr[5:2]];

	always @(posedge clk) begin : dmem_write
		int k;
		if (resetn && mem_wstrb != 4'b0000) begin
			for (k = 0; k < 4; k++) begin
				if (mem_wstrb[k]) begin
					dmem[mem_addr[5:2]][8*k +: 8] <= mem_wdata[8*k +: 8]; // low lanes
				end
			end
		end
	end

	function automatic logic [31:0] rand_below(input logic [31:0] n);
		logic [31:0] r;
		r = $random(seed);
		rand_below = r % n;
	endfunction

	function automatic logic [31:0] fill_word(input logic [31:0] a);
		fill_word = a ^ {a[15:0], a[31:16]} ^ 32'h6c07_8965;
	endfunction

	function automatic logic [31:0] enc_r(input logic [31:0] f7, rs2, rs1, f3, rd);
		enc_r = {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP[6:0]};
	endfunction

	function automatic logic [31:0] enc_i(input logic [31:0] imm, rs1, f3, rd, opc);
		enc_i = {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
	endfunction

	function automatic logic [31:0] enc_s(input logic [31:0] imm, rs2, rs1, f3);
		enc_s = {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], OPC_STORE[6:0]};
	endfunction

	function automatic logic [31:0] enc_b(input logic [31:0] imm, rs2, rs1, f3);
		enc_b = {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
			OPC_BRANCH[6:0]};
	endfunction

	function automatic logic [31:0] enc_j(input logic [31:0] imm, rd);
		enc_j = {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPC_JAL[6:0]};
	endfunction

	function automatic logic [31:0] enc_u(input logic [31:0] imm20, rd, opc);
		enc_u = {imm20[19:0], rd[4:0], opc[6:0]};
	endfunction

	function automatic logic [31:0] alu(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, b);
		case (f3)
			3'd0: alu = alt ? a - b : a + b;
			3'd1: alu = a << b[4:0];
			3'd2: alu = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: alu = (a < b) ? 32'd1 : 32'd0;
			3'd4: alu = a ^ b;
			3'd5: begin
				if (alt) begin
					alu = $signed(a) >>> b[4:0];
				end else begin
					alu = a >> b[4:0];
				end
			end
			3'd6: alu = a | b;
			default: alu = a & b;
		endcase
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, exp);
		assert (got === exp) else begin
			errors++;
			$display("MISMATCH %s: got %h expected %h", name, got, exp);
		end
	endtask

	// ISA semantics of one word, without touching the model state
	task automatic predict(input logic [31:0] w);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] imm_b;
		logic [31:0] imm_j;
		logic [31:0] word;
		logic [2:0]  f3;
		logic        taken;
		f3    = w[14:12];
		a     = m_regs[w[19:15]];
		b     = m_regs[w[24:20]];
		imm_i = {{20{w[31]}}, w[31:20]};
		imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
		imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
		{p_bad, p_load, p_store, p_wr} = 4'b0001;
		p_rd    = w[11:7];
		p_res   = '0;
		p_npc   = m_pc + 32'd4;
		p_addr  = '0;
		p_wdata = '0;
		p_wstrb = 4'b0000;
		p_rmask = 4'b0000;
		case ({25'b0, w[6:0]})
			OPC_LUI:   p_res = {w[31:12], 12'b0};
			OPC_AUIPC: p_res = m_pc + {w[31:12], 12'b0};
			OPC_JAL: begin
				p_res = m_pc + 32'd4;
				p_npc = m_pc + imm_j;
			end
			OPC_JALR: begin
				p_res = m_pc + 32'd4;
				p_npc = (a + imm_i) & ~32'd1;
			end
			OPC_BRANCH: begin
				p_wr = 1'b0;
				case (f3)
					3'd0: taken = (a == b);
					3'd1: taken = (a != b);
					3'd4: taken = $signed(a) < $signed(b);
					3'd5: taken = $signed(a) >= $signed(b);
					3'd6: taken = a < b;
					default: taken = a >= b;
				endcase
				if (taken) begin
					p_npc = m_pc + imm_b;
				end
			end
			OPC_LOAD: begin
				p_load = 1'b1;
				p_addr = a + imm_i;
				word   = m_mem[p_addr[5:2]];
				case (f3)
					3'd0: p_res = {{24{word[7]}}, word[7:0]};
					3'd1: p_res = {{16{word[15]}}, word[15:0]};
					3'd4: p_res = {24'b0, word[7:0]};
					3'd5: p_res = {16'b0, word[15:0]};
					default: p_res = word;
				endcase
				p_rmask = (f3[1:0] == 2'd0) ? 4'b0001 : (f3[1:0] == 2'd1) ? 4'b0011 : 4'b1111;
			end
			OPC_STORE: begin
				p_wr    = 1'b0;
				p_store = 1'b1;
				p_addr  = a + {{20{w[31]}}, w[31:25], w[11:7]};
				p_wdata = b; // whole rs2 on the low lanes
				p_wstrb = (f3 == 3'd0) ? 4'b0001 : (f3 == 3'd1) ? 4'b0011 : 4'b1111;
			end
			OPC_IMM, OPC_OP: p_res = alu(f3, w[30] && (w[5] || f3 == 3'd5), a, w[5] ? b : imm_i);
			default: p_bad = 1'b1;
		endcase
		if (p_npc[1:0] != 2'b00) begin
			p_bad = 1'b1;
		end
	endtask

	task automatic retire;
		int k;
		if (p_store) begin
			for (k = 0; k < 4; k++) begin
				if (p_wstrb[k]) begin
					m_mem[p_addr[5:2]][8*k +: 8] = p_wdata[8*k +: 8];
				end
			end
		end
		if (p_wr && p_rd != 5'd0) begin
			m_regs[p_rd] = p_res;
		end
		m_pc = p_npc;
	endtask

	task automatic check_cycle;
		check_val("insn_addr", insn_addr, m_pc);
		check_val("mem_instr", {31'b0, mem_instr}, 32'd0);
		if (m_halted) begin
			check_val("trap", {31'b0, trap}, 32'd1);
			check_val("mem_wstrb", {28'b0, mem_wstrb}, 32'd0);
		end else begin
			predict(imem[m_pc[9:2]]);
			if (p_bad) begin
				check_val("trap", {31'b0, trap}, 32'd1);
				check_val("mem_wstrb", {28'b0, mem_wstrb}, 32'd0);
				m_halted = 1'b1;
			end else begin
				check_val("trap", {31'b0, trap}, 32'd0);
				check_val("mem_valid", {31'b0, mem_valid}, {31'b0, p_load || p_store});
				if ((p_load || p_store) && !mem_ready) begin
					check_val("mem_wstrb", {28'b0, mem_wstrb}, 32'd0); // stalled
				end else begin
					check_val("mem_wstrb", {28'b0, mem_wstrb}, {28'b0, p_wstrb});
					if (p_store) begin
						check_val("mem_addr", mem_addr, p_addr);
						check_val("mem_wdata", mem_wdata, p_wdata);
					end
					if (p_load) begin
						check_val("mem_addr", mem_addr, p_addr);
						check_val("mem_rmask", {28'b0, mem_rmask}, {28'b0, p_rmask});
					end
					retire();
				end
			end
		end
	endtask

	task automatic build_program(input logic end_on_csr);
		int          idx;
		int          k;
		int          tgt;
		logic [31:0] rd;
		logic [31:0] rs1;
		logic [31:0] rs2;
		logic [31:0] f3;
		logic [31:0] imm;
		logic [31:0] sel;
		for (k = 0; k < WIN_WORDS; k++) begin
			dmem[k]  = fill_word(DATA_BASE + 4 * k);
			m_mem[k] = dmem[k];
		end
		imem[0] = enc_u(DATA_BASE >> 12, 31, OPC_LUI); // x31 data base
		imem[1] = enc_s(0, 2, 31, 2);                   // x2 before any write
		imem[2] = enc_u(`MINRV_RESET_PC >> 12, 30, OPC_LUI); // x30 code base
		idx = 3;
		for (k = 1; k < 30; k++) begin
			if (k != 2) begin
				imem[idx] = enc_i(rand_below(4096), 0, 0, k, OPC_IMM);
				idx++;
			end
		end
		for (idx = 31; idx < PROG_LEN - 1; idx++) begin
			rd  = 1 + rand_below(29); // x30 and x31 stay bases
			rs1 = rand_below(32);
			rs2 = rand_below(32);
			f3  = rand_below(8);
			tgt = idx + 1 + rand_below(4); // forward only, inside the program
			if (tgt > PROG_LEN - 1) begin
				tgt = PROG_LEN - 1;
			end
			if (idx % 4 == 0) begin
				imem[idx] = enc_s(4 * rand_below(WIN_WORDS), (idx / 4) % 32, 31, 2);
			end else begin
				case (rand_below(10))
					0, 1, 2: begin
						imm = rand_below(4096);
						if (f3 == 1) begin
							imm = rand_below(32);
						end else if (f3 == 5) begin
							imm = rand_below(32) | (rand_below(2) << 10); // srai
						end
						imem[idx] = enc_i(imm, rs1, f3, rd, OPC_IMM);
					end
					3, 4: begin
						imm = ((f3 == 0 || f3 == 5) && rand_below(2) == 1) ? 32'h20 : 32'h0;
						imem[idx] = enc_r(imm, rs2, rs1, f3, rd);
					end
					5: imem[idx] = enc_u(rand_below(32'h10_0000), rd,
						rand_below(2) == 1 ? OPC_LUI : OPC_AUIPC);
					6: begin
						sel = rand_below(5);
						imem[idx] = enc_i(4 * rand_below(WIN_WORDS), 31, sel > 2 ? sel + 1 : sel,
							rd, OPC_LOAD);
					end
					7: imem[idx] = enc_s(4 * rand_below(WIN_WORDS), rs2, 31, rand_below(3));
					8: begin
						sel = rand_below(6);
						imem[idx] = enc_b((tgt - idx) * 4, rs2, rs1, sel < 2 ? sel : sel + 2);
					end
					default: begin
						if (rand_below(2) == 1) begin
							imem[idx] = enc_j((tgt - idx) * 4, rd);
						end else begin
							imem[idx] = enc_i(tgt * 4 + rand_below(2), 30, 0, rd, OPC_JALR);
						end
					end
				endcase
			end
		end
		// csrrs a0, cycle, x0 or a jalr to an address with bit 1 set
		imem[PROG_LEN - 1] = end_on_csr ? 32'hc000_2573 : enc_i(2, 30, 0, 1, OPC_JALR);
	endtask

	task automatic run_program(input logic end_on_csr);
		int k;
		int halted_cycles;
		build_program(end_on_csr);
		for (k = 0; k < 32; k++) begin
			m_regs[k] = '0;
		end
		m_regs[2] = `MINRV_STACK_ADDR;
		m_pc      = `MINRV_RESET_PC;
		m_halted  = 1'b0;
		@(posedge clk);
		resetn    <= 1'b0;
		mem_ready <= 1'b0;
		repeat (2) @(posedge clk);
		resetn <= 1'b1;
		halted_cycles = 0;
		while (halted_cycles < 8) begin // watch the halt for a few cycles
			@(negedge clk);
			check_cycle();
			if (m_halted) begin
				halted_cycles++;
				if (halted_cycles == 2) begin
					// a legal store under the stopped pc, only the halt flag holds it back
					imem[m_pc[9:2]] = enc_s(0, 2, 31, 2);
				end
			end
			@(posedge clk);
			mem_ready <= (rand_below(4) != 0);
		end
	endtask

	initial begin
		clk       = 1'b0;
		resetn    = 1'b0;
		mem_ready = 1'b0;
		errors    = 0;
		run_program(1'b1);
		run_program(1'b0);
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: the programs did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+include
hdl/rv_isa_pkg.sv
hdl/core_bus_pkg.sv
hdl/insn_decoder.sv
hdl/exec_unit.sv
hdl/reg_file.sv
hdl/minrv_core.sv
testbench/tb_minrv_core.sv

//--- Bender.yml
package:
  name: minrv_core

sources:
  - include_dirs:
      - include
    files:
      - hdl/rv_isa_pkg.sv
      - hdl/core_bus_pkg.sv
      - hdl/insn_decoder.sv
      - hdl/exec_unit.sv
      - hdl/reg_file.sv
      - hdl/minrv_core.sv

  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_minrv_core.sv
